/* hw/axil_reg_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_reg_port
  import miner_ocl_pkg::*;
(
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,
  // Write address channel
  input  logic  awvalid,
  input  addr_t awaddr,
  output logic  awready,
  // Write data channel
  input  logic  wvalid,
  input  data_t wdata,
  output logic  wready,
  // Write response channel
  output logic  bvalid,
  input  logic  bready,
  // Read address channel
  input  logic  arvalid,
  input  addr_t araddr,
  output logic  arready,
  // Read data channel
  output logic  rvalid,
  output data_t rdata,
  input  logic  rready,
  // Write commit toward the register blocks
  output logic  wr_en,
  output addr_t wr_addr,
  output data_t wr_data,
  // Read lookup
  output addr_t rd_addr,
  input  data_t rd_data,
  input  logic  rd_hash,
  output logic  hash_re
);

  logic  wr_active;
  addr_t wr_addr_q;
  logic  b_done;
  logic  ar_take;
  logic  ar_pend;
  addr_t rd_addr_q;
  logic  r_done;

  // ----------------------------------------------------------
  // Write side
  // ----------------------------------------------------------
  // One write in flight, address taken only when idle
  assign awready = !wr_active;
  // Data accepted once per write, never while response pending
  assign wready  = wr_active && !bvalid && wvalid;
  assign b_done  = bvalid && bready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end
    else
    begin
      // Write ends on the response handshake
      if (b_done)
        wr_active <= 1'b0;
      else if (awvalid && awready)
        wr_active <= 1'b1;
      // Response follows the commit by one edge
      if (b_done)
        bvalid <= 1'b0;
      else if (wready)
        bvalid <= 1'b1;
    end
  end

  // Captured write address
  always_ff @(posedge clk_main_a0)
  begin
    if (awvalid && awready)
      wr_addr_q <= awaddr;
  end

  // Commit is the data handshake cycle itself
  assign wr_en   = wready;
  assign wr_addr = wr_addr_q;
  assign wr_data = wdata;

  // ----------------------------------------------------------
  // Read side
  // ----------------------------------------------------------
  assign arready = !ar_pend && !rvalid;
  assign ar_take = arvalid && arready;
  assign r_done  = rvalid && rready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      ar_pend <= 1'b0;
      rvalid  <= 1'b0;
      hash_re <= 1'b0;
    end
    else
    begin
      ar_pend <= ar_take;
      if (r_done)
      begin
        rvalid  <= 1'b0;
        hash_re <= 1'b0;
      end
      else if (ar_pend)
      begin
        rvalid  <= 1'b1;
        // Hash read level tracks the beat
        hash_re <= rd_hash;
      end
    end
  end

  // Address and returned data, frozen while rvalid waits
  always_ff @(posedge clk_main_a0)
  begin
    if (ar_take)
      rd_addr_q <= araddr;
    if (ar_pend)
      rdata <= rd_data;
  end

  assign rd_addr = rd_addr_q;

endmodule

`default_nettype wire

/* hw/cl_miner_ocl.sv */
`timescale 1ns/1ps
`default_nettype none

module cl_miner_ocl
  import miner_ocl_pkg::*;
(
  input  logic    clk_main_a0,
  input  logic    rst_main_n_sync,
  // Host AXI-Lite register port
  input  logic    awvalid,
  input  addr_t   awaddr,
  output logic    awready,
  input  logic    wvalid,
  input  data_t   wdata,
  output logic    wready,
  output logic    bvalid,
  input  logic    bready,
  input  logic    arvalid,
  input  addr_t   araddr,
  output logic    arready,
  output logic    rvalid,
  output data_t   rdata,
  input  logic    rready,
  // Virtual DIP and LED
  input  vled_t   vdip,
  output vled_t   vled,
  // From the miner core
  input  status_t status,
  input  data_t   nonce,
  input  data_t   heavyhash,
  // To the miner core
  output logic    hash_re,
  output data_t   block_header,
  output logic    block_header_we,
  output data_t   matrix_in,
  output logic    matrix_fifo_we,
  output data_t   target,
  output logic    target_we,
  output data_t   nonce_size,
  output logic    start,
  output logic    stop,
  output hsel_t   hash_select
);

  // Write commit
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;
  // Read lookup
  addr_t rd_addr;
  data_t rd_data;
  logic  rd_hash;
  // Register contents for readback
  data_t hello;
  vled_t vled_reg;

  // ----------------------------------------------------------
  // Bus front end
  // ----------------------------------------------------------
  axil_reg_port u_axil_reg_port (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rready          (rready),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .rd_hash         (rd_hash),
    .hash_re         (hash_re)
  );

  // ----------------------------------------------------------
  // Register blocks
  // ----------------------------------------------------------
  miner_ctrl_regs u_miner_ctrl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .block_header    (block_header),
    .block_header_we (block_header_we),
    .matrix_in       (matrix_in),
    .matrix_fifo_we  (matrix_fifo_we),
    .target          (target),
    .target_we       (target_we),
    .nonce_size      (nonce_size),
    .start           (start),
    .stop            (stop),
    .hash_select     (hash_select)
  );

  scratch_vled u_scratch_vled (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .vdip            (vdip),
    .hello           (hello),
    .vled_reg        (vled_reg),
    .vled            (vled)
  );

  // Readback select
  ocl_read_mux u_ocl_read_mux (
    .rd_addr   (rd_addr),
    .hello     (hello),
    .vled_reg  (vled_reg),
    .status    (status),
    .nonce     (nonce),
    .heavyhash (heavyhash),
    .rd_data   (rd_data),
    .rd_hash   (rd_hash)
  );

endmodule

`default_nettype wire

/* hw/miner_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module miner_ctrl_regs
  import miner_ocl_pkg::*;
(
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  // Strobed words into the miner
  output data_t block_header,
  output logic  block_header_we,
  output data_t matrix_in,
  output logic  matrix_fifo_we,
  output data_t target,
  output logic  target_we,
  // Held settings and pulses
  output data_t nonce_size,
  output logic  start,
  output logic  stop,
  output hsel_t hash_select
);

  logic hit_header;
  logic hit_matrix;
  logic hit_target;
  logic hit_nsize;
  logic hit_start;
  logic hit_stop;
  logic hit_hsel;

  // Address decode of the commit
  assign hit_header = wr_en && (wr_addr == ADDR_BLOCK_HEADER);
  assign hit_matrix = wr_en && (wr_addr == ADDR_MATRIX);
  assign hit_target = wr_en && (wr_addr == ADDR_TARGET);
  assign hit_nsize  = wr_en && (wr_addr == ADDR_NONCE_SIZE);
  assign hit_start  = wr_en && (wr_addr == ADDR_START);
  assign hit_stop   = wr_en && (wr_addr == ADDR_STOP);
  assign hit_hsel   = wr_en && (wr_addr == ADDR_HASH_SEL);

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      block_header_we <= 1'b0;
      matrix_fifo_we  <= 1'b0;
      target_we       <= 1'b0;
      block_header    <= '0;
      matrix_in       <= '0;
      target          <= '0;
      start           <= 1'b0;
      stop            <= 1'b0;
      nonce_size      <= '0;
      hash_select     <= '0;
    end
    else
    begin
      // One-cycle strobes, word zero outside the strobe
      block_header_we <= hit_header;
      matrix_fifo_we  <= hit_matrix;
      target_we       <= hit_target;
      block_header    <= hit_header ? wr_data : '0;
      matrix_in       <= hit_matrix ? wr_data : '0;
      target          <= hit_target ? wr_data : '0;
      // Run control pulses
      start <= hit_start;
      stop  <= hit_stop;
      // Held until rewritten
      if (hit_nsize)
        nonce_size <= wr_data;
      // Low bits only, so the select wraps at BLK_CNT
      if (hit_hsel)
        hash_select <= wr_data[HSEL_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* hw/miner_ocl_pkg.sv */
`default_nettype none

package miner_ocl_pkg;

  // ----------------------------------------------------------
  // Bus and field widths
  // ----------------------------------------------------------
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int VLED_W   = 16;
  localparam int STATUS_W = 2;
  // Hash blocks held inside the miner core
  localparam int BLK_CNT  = 4;
  localparam int HSEL_W   = $clog2(BLK_CNT);

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [VLED_W-1:0]   vled_t;
  typedef logic [STATUS_W-1:0] status_t;
  typedef logic [HSEL_W-1:0]   hsel_t;

  // Read value for holes in the map
  localparam data_t UNIMPL_VALUE = 32'hDEAD_BEEF;

  // ----------------------------------------------------------
  // Register map, one word per register
  // ----------------------------------------------------------
  localparam addr_t ADDR_HELLO        = 32'h0000_0500;
  localparam addr_t ADDR_VLED         = 32'h0000_0504;
  localparam addr_t ADDR_BLOCK_HEADER = 32'h0000_0508;
  localparam addr_t ADDR_MATRIX       = 32'h0000_050C;
  localparam addr_t ADDR_TARGET       = 32'h0000_0510;
  localparam addr_t ADDR_NONCE_SIZE   = 32'h0000_0514;
  localparam addr_t ADDR_START        = 32'h0000_0518;
  localparam addr_t ADDR_STOP         = 32'h0000_051C;
  localparam addr_t ADDR_HASH_SEL     = 32'h0000_0520;
  // Read-only miner results
  localparam addr_t ADDR_STATUS       = 32'h0000_0524;
  localparam addr_t ADDR_NONCE        = 32'h0000_0528;
  localparam addr_t ADDR_HEAVYHASH    = 32'h0000_052C;

endpackage

`default_nettype wire

/* hw/ocl_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module ocl_read_mux
  import miner_ocl_pkg::*;
(
  input  addr_t   rd_addr,
  input  data_t   hello,
  input  vled_t   vled_reg,
  // Miner results
  input  status_t status,
  input  data_t   nonce,
  input  data_t   heavyhash,
  output data_t   rd_data,
  output logic    rd_hash
);

  data_t hello_swapped;

  // Scratch reads back with byte order reversed
  assign hello_swapped = {hello[7:0], hello[15:8], hello[23:16], hello[31:24]};

  always_comb
  begin
    case (rd_addr)
      ADDR_HELLO:     rd_data = hello_swapped;
      // Narrow registers zero-extended to a word
      ADDR_VLED:      rd_data = {{(DATA_W-VLED_W){1'b0}}, vled_reg};
      ADDR_STATUS:    rd_data = {{(DATA_W-STATUS_W){1'b0}}, status};
      ADDR_NONCE:     rd_data = nonce;
      ADDR_HEAVYHASH: rd_data = heavyhash;
      default:        rd_data = UNIMPL_VALUE;
    endcase
  end

  // Miner pops the hash word on this read
  assign rd_hash = (rd_addr == ADDR_HEAVYHASH);

endmodule

`default_nettype wire

/* hw/scratch_vled.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_vled
  import miner_ocl_pkg::*;
(
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  // Virtual DIP switches, asynchronous to the bus clock
  input  vled_t vdip,
  output data_t hello,
  output vled_t vled_reg,
  output vled_t vled
);

  vled_t vdip_q1;
  vled_t vdip_q2;

  // ----------------------------------------------------------
  // Scratch word and LED shadow
  // ----------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      hello    <= '0;
      vled_reg <= '0;
    end
    else
    begin
      if (wr_en && (wr_addr == ADDR_HELLO))
        hello <= wr_data;
      // Low half shadowed one edge behind
      vled_reg <= hello[VLED_W-1:0];
    end
  end

  // ----------------------------------------------------------
  // DIP sync and masked LED output
  // ----------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
      vled    <= '0;
    end
    else
    begin
      // Two-flop synchronizer
      vdip_q1 <= vdip;
      vdip_q2 <= vdip_q1;
      // Switch off clears the matching LED
      vled    <= vled_reg & vdip_q2;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sources.f --top-module tb_cl_miner_ocl \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
exit 1

/* sources.f */
hw/miner_ocl_pkg.sv
hw/axil_reg_port.sv
hw/miner_ctrl_regs.sv
hw/scratch_vled.sv
hw/ocl_read_mux.sv
hw/cl_miner_ocl.sv
verification/tb_cl_miner_ocl.sv

/* verification/tb_cl_miner_ocl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cl_miner_ocl
  import miner_ocl_pkg::*;
();

  // Generous bound over the directed sequence length
  localparam int TIMEOUT_CYCLES = 3000;

  logic    clk_main_a0;
  logic    rst_main_n_sync;
  logic    awvalid;
  addr_t   awaddr;
  logic    awready;
  logic    wvalid;
  data_t   wdata;
  logic    wready;
  logic    bvalid;
  logic    bready;
  logic    arvalid;
  addr_t   araddr;
  logic    arready;
  logic    rvalid;
  data_t   rdata;
  logic    rready;
  vled_t   vdip;
  vled_t   vled;
  status_t status;
  data_t   nonce;
  data_t   heavyhash;
  logic    hash_re;
  data_t   block_header;
  logic    block_header_we;
  data_t   matrix_in;
  logic    matrix_fifo_we;
  data_t   target;
  logic    target_we;
  data_t   nonce_size;
  logic    start;
  logic    stop;
  hsel_t   hash_select;

  int mismatch_cnt = 0;
  int other_cnt    = 0;
  int leak_cnt     = 0;
  int cycle_cnt    = 0;
  // Strobe tallies kept by the monitor
  int    hdr_hits   = 0;
  int    mat_hits   = 0;
  int    tgt_hits   = 0;
  int    start_hits = 0;
  int    stop_hits  = 0;
  data_t hdr_seen;
  data_t mat_seen;
  data_t tgt_seen;

  cl_miner_ocl u_dut (.*);

  // ----------------------------------------------------------
  // Clock, timeout and strobe monitor
  // ----------------------------------------------------------
  initial
  begin
    clk_main_a0 = 1'b0;
    forever #2 clk_main_a0 = ~clk_main_a0;
  end

  always @(posedge clk_main_a0)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run exceeded %0d cycles waiting on a handshake", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // Strobes sampled mid-cycle
  always @(negedge clk_main_a0)
  begin
    if (rst_main_n_sync)
    begin
      if (block_header_we)
      begin
        hdr_hits++;
        hdr_seen = block_header;
      end
      else if (block_header != '0)
      begin
        leak_cnt++;
        $display("block_header word is nonzero while block_header_we is low");
      end
      if (matrix_fifo_we)
      begin
        mat_hits++;
        mat_seen = matrix_in;
      end
      else if (matrix_in != '0)
      begin
        leak_cnt++;
        $display("matrix_in word is nonzero while matrix_fifo_we is low");
      end
      if (target_we)
      begin
        tgt_hits++;
        tgt_seen = target;
      end
      else if (target != '0)
      begin
        leak_cnt++;
        $display("target word is nonzero while target_we is low");
      end
      if (start)
        start_hits++;
      if (stop)
        stop_hits++;
    end
  end

  // ----------------------------------------------------------
  // Helpers and compare tasks
  // ----------------------------------------------------------
  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_main_a0);
    #1;
  endtask

  function automatic data_t reverse_bytes(input data_t w);
    data_t r;
    for (int i = 0; i < DATA_W / 8; i++)
      r[8*i +: 8] = w[DATA_W-8-8*i +: 8];
    return r;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act)
    begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_vled(input string name, input vled_t exp, input vled_t act);
    if (exp !== act)
    begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_hsel(input string name, input hsel_t exp, input hsel_t act);
    if (exp !== act)
    begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      mismatch_cnt++;
      $display("mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act)
    begin
      mismatch_cnt++;
      $display("mismatch %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // Bus tasks
  // ----------------------------------------------------------
  task automatic axil_write(input addr_t addr, input data_t data, input int bp_cycles);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    bready  = 1'b0;
    while (!awready)
      step();
    // Address taken at this edge
    step();
    awvalid = 1'b0;
    while (!wready)
      step();
    // Commit edge
    step();
    wvalid = 1'b0;
    if (!bvalid)
    begin
      other_cnt++;
      $display("bvalid did not rise one cycle after the write commit to %h", addr);
    end
    // Response held off by the host
    repeat (bp_cycles)
    begin
      step();
      check_bit("bp_bvalid", 1'b1, bvalid);
      check_bit("bp_awready", 1'b0, awready);
    end
    bready = 1'b1;
    step();
    bready = 1'b0;
    check_bit("b_done_bvalid", 1'b0, bvalid);
  endtask

  task automatic axil_read(input addr_t addr, input int bp_cycles,
                           output data_t data, output logic hre);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = 1'b0;
    while (!arready)
      step();
    step();
    arvalid = 1'b0;
    while (!rvalid)
      step();
    data = rdata;
    hre  = hash_re;
    // Beat must stay frozen under back-pressure
    repeat (bp_cycles)
    begin
      step();
      check_bit("bp_rvalid", 1'b1, rvalid);
      check_data("bp_rdata", data, rdata);
      check_bit("bp_hash_re", hre, hash_re);
      check_bit("bp_arready", 1'b0, arready);
    end
    rready = 1'b1;
    step();
    rready = 1'b0;
    check_bit("r_done_rvalid", 1'b0, rvalid);
    check_bit("r_done_hash_re", 1'b0, hash_re);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_scratch();
    data_t w;
    data_t got;
    logic  hre;
    w = $urandom();
    axil_write(ADDR_HELLO, w, 0);
    axil_read(ADDR_HELLO, 0, got, hre);
    check_data("scratch_readback", reverse_bytes(w), got);
    check_bit("scratch_hash_re", 1'b0, hre);
  endtask

  task automatic test_vled();
    data_t w;
    data_t r;
    data_t got;
    logic  hre;
    r    = $urandom();
    vdip = r[VLED_W-1:0];
    w    = $urandom();
    axil_write(ADDR_HELLO, w, 0);
    repeat (5)
      step();
    check_vled("vled_after_write", w[VLED_W-1:0] & vdip, vled);
    // LED register reads back unmasked and zero-extended
    axil_read(ADDR_VLED, 0, got, hre);
    check_data("vled_readback", data_t'(w[VLED_W-1:0]), got);
    check_bit("vled_hash_re", 1'b0, hre);
    // New switch setting with scratch unchanged
    r    = $urandom();
    vdip = r[VLED_W-1:0];
    repeat (5)
      step();
    check_vled("vled_after_dip", w[VLED_W-1:0] & vdip, vled);
  endtask

  task automatic test_strobes();
    data_t hdr_w;
    data_t mat_w;
    data_t tgt_w;
    int    hdr_base;
    int    mat_base;
    int    tgt_base;
    int    start_base;
    int    stop_base;
    hdr_base   = hdr_hits;
    mat_base   = mat_hits;
    tgt_base   = tgt_hits;
    start_base = start_hits;
    stop_base  = stop_hits;
    hdr_w = $urandom();
    mat_w = $urandom();
    tgt_w = $urandom();
    axil_write(ADDR_BLOCK_HEADER, hdr_w, 0);
    axil_write(ADDR_MATRIX, mat_w, 0);
    axil_write(ADDR_TARGET, tgt_w, 0);
    axil_write(ADDR_START, $urandom(), 0);
    axil_write(ADDR_STOP, $urandom(), 0);
    repeat (2)
      step();
    check_count("header_strobe_cycles", 1, hdr_hits - hdr_base);
    check_data("header_word", hdr_w, hdr_seen);
    check_count("matrix_strobe_cycles", 1, mat_hits - mat_base);
    check_data("matrix_word", mat_w, mat_seen);
    check_count("target_strobe_cycles", 1, tgt_hits - tgt_base);
    check_data("target_word", tgt_w, tgt_seen);
    check_count("start_pulses", 1, start_hits - start_base);
    check_count("stop_pulses", 1, stop_hits - stop_base);
  endtask

  task automatic test_held();
    data_t ns;
    data_t hs;
    ns = $urandom();
    hs = $urandom();
    axil_write(ADDR_NONCE_SIZE, ns, 0);
    axil_write(ADDR_HASH_SEL, hs, 0);
    check_data("nonce_size", ns, nonce_size);
    check_hsel("hash_select", hsel_t'(hs % BLK_CNT), hash_select);
    // Unrelated writes leave both settings alone
    axil_write(ADDR_HELLO, $urandom(), 0);
    axil_write(ADDR_TARGET, $urandom(), 0);
    check_data("nonce_size_held", ns, nonce_size);
    check_hsel("hash_select_held", hsel_t'(hs % BLK_CNT), hash_select);
  endtask

  task automatic test_reads();
    data_t r;
    data_t got;
    logic  hre;
    // Miner model outputs
    r         = $urandom();
    status    = r[STATUS_W-1:0];
    nonce     = $urandom();
    heavyhash = $urandom();
    axil_read(ADDR_STATUS, 0, got, hre);
    check_data("status_read", data_t'(status), got);
    check_bit("status_hash_re", 1'b0, hre);
    axil_read(ADDR_NONCE, 0, got, hre);
    check_data("nonce_read", nonce, got);
    check_bit("nonce_hash_re", 1'b0, hre);
    axil_read(ADDR_HEAVYHASH, 0, got, hre);
    check_data("heavyhash_read", heavyhash, got);
    check_bit("heavyhash_hash_re", 1'b1, hre);
    axil_read(32'h0000_0600, 0, got, hre);
    check_data("unmapped_read", UNIMPL_VALUE, got);
    check_bit("unmapped_hash_re", 1'b0, hre);
  endtask

  task automatic test_backpressure();
    data_t w;
    data_t got;
    logic  hre;
    w = $urandom();
    axil_write(ADDR_HELLO, w, 6);
    axil_read(ADDR_HELLO, 6, got, hre);
    check_data("bp_readback", reverse_bytes(w), got);
    check_bit("bp_readback_hash_re", 1'b0, hre);
    // Hash read level held high while the host stalls
    axil_read(ADDR_HEAVYHASH, 6, got, hre);
    check_data("bp_heavyhash", heavyhash, got);
    check_bit("bp_heavyhash_hash_re", 1'b1, hre);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial
  begin
    void'($urandom(63));
    rst_main_n_sync = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    vdip      = '0;
    status    = '0;
    nonce     = '0;
    heavyhash = '0;
    repeat (8)
      @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    step();
    // State straight out of reset
    check_bit("reset_awready", 1'b1, awready);
    check_bit("reset_arready", 1'b1, arready);
    check_bit("reset_bvalid", 1'b0, bvalid);
    check_bit("reset_rvalid", 1'b0, rvalid);
    check_bit("reset_hash_re", 1'b0, hash_re);
    check_bit("reset_start", 1'b0, start);
    check_bit("reset_stop", 1'b0, stop);
    check_vled("reset_vled", '0, vled);
    test_scratch();
    test_vled();
    test_strobes();
    test_held();
    test_reads();
    test_backpressure();
    repeat (4)
      step();
    $display("Errors: %0d mismatches, %0d protocol, %0d strobe word leaks",
             mismatch_cnt, other_cnt, leak_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0 && leak_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
